/* filelist.f */
src/fetch_pkg.sv
src/fetch_pc_gen.sv
src/fetch_ibus_port.sv
src/fetch_stage.sv
src/fetch_top.sv
testbench/fetch_assertions.sv
testbench/fetch_tb.sv

/* src/fetch_ibus_port.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_ibus_port import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,

	// From pc generator and fetch stage
	input  logic [31:0] pc_i,
	input  logic        advance_i,
	input  logic        flush_i,

	// External memory
	output logic [31:0] ibus_adr_o,
	output logic        ibus_req_o,
	input  logic [31:0] ibus_dat_i,
	input  logic        ibus_ack_i,
	input  logic        ibus_err_i,

	// Response to the fetch stage
	output logic [31:0] rsp_dat_o,
	output logic        rsp_ack_o,
	output logic        rsp_err_o,
	output logic [31:0] rsp_adr_o,
	output itag_e       rsp_tag_o,
	output logic        pending_o
);

	ibus_state_e state_q;
	ibus_state_e state_d;

	// Transfer address and fault tag, latched at issue
	logic [31:0] adr_q;
	itag_e       tag_q;

	// Issue enable, set once reset has been seen low
	logic run_q;
	// Flush seen while waiting, transfer result is stale
	logic drop_q;

	logic tlb_miss;
	logic prot_fault;
	logic fault;
	logic issue;
	logic rsp_any;

	////////////////////////////////////////////////////////////
	// Fault windows
	////////////////////////////////////////////////////////////

	assign tlb_miss   = pc_i >= TLB_MISS_BASE;
	assign prot_fault = (pc_i >= PROT_BASE) && (pc_i <= PROT_LIMIT);
	assign fault      = tlb_miss | prot_fault;

	// Leave IDLE unless a redirect is on its way
	assign issue = (state_q == IBUS_IDLE) && run_q && !flush_i;

	// Bus only finishes a transfer in WAIT
	assign rsp_any = (state_q == IBUS_WAIT) && (ibus_ack_i || ibus_err_i);

	////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////

	always_comb begin
		state_d = state_q;
		case (state_q)
			IBUS_IDLE: begin
				if (issue) begin
					state_d = fault ? IBUS_FAULT : IBUS_WAIT;
				end
			end
			IBUS_WAIT: begin
				// Stale or consumed result goes straight back
				if (rsp_any) begin
					state_d = (advance_i || flush_i || drop_q) ? IBUS_IDLE : IBUS_DONE;
				end
			end
			IBUS_FAULT: begin
				state_d = (advance_i || flush_i) ? IBUS_IDLE : IBUS_DONE;
			end
			default: begin
				// Held response, waiting for consume or redirect
				if (advance_i || flush_i) begin
					state_d = IBUS_IDLE;
				end
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q <= IBUS_IDLE;
			run_q   <= 1'b0;
			drop_q  <= 1'b0;
		end
		else begin
			state_q <= state_d;
			run_q   <= 1'b1;
			if (state_q != IBUS_WAIT || rsp_any) begin
				drop_q <= 1'b0;
			end
			else if (flush_i) begin
				drop_q <= 1'b1;
			end
		end
	end

	// Address and tag of the slot being fetched
	always_ff @(posedge clk) begin
		if (issue) begin
			adr_q <= pc_i;
			tag_q <= tlb_miss ? ITAG_TE : ITAG_PE;
		end
	end

	////////////////////////////////////////////////////////////
	// Bus and response outputs
	////////////////////////////////////////////////////////////

	// No external cycle for window faults
	assign ibus_req_o = (issue && !fault) || (state_q == IBUS_WAIT);
	assign ibus_adr_o = (state_q == IBUS_WAIT) ? adr_q : pc_i;

	assign rsp_dat_o = ibus_dat_i;
	assign rsp_ack_o = (state_q == IBUS_WAIT) && ibus_ack_i;
	assign rsp_err_o = ((state_q == IBUS_WAIT) && ibus_err_i) || (state_q == IBUS_FAULT);
	assign rsp_adr_o = adr_q;

	// Window faults carry their latched tag, bus errors are BE
	assign rsp_tag_o = (state_q == IBUS_FAULT) ? tag_q :
	                   (rsp_err_o ? ITAG_BE : ITAG_NONE);

	assign pending_o = state_q == IBUS_WAIT;

endmodule

`default_nettype wire

/* src/fetch_pc_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_pc_gen import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,

	// Consume strobe from the fetch stage
	input  logic        advance_i,

	// Redirect from the pipeline
	input  logic        flush_i,
	input  logic [31:0] flush_pc_i,

	// Current fetch address
	output logic [31:0] pc_o
);

	////////////////////////////////////////////////////////////
	// Word address register
	////////////////////////////////////////////////////////////

	// Only the word index is stored
	// so the low two bits of pc are always zero
	logic [29:0] pc_word_q;
	logic [29:0] pc_word_d;

	// Word index of the reset vector
	localparam logic [29:0] RESET_WORD = RESET_PC[31:2];

	// Next address selection
	// Flush wins over advance
	always_comb begin
		pc_word_d = pc_word_q;
		if (flush_i) begin
			pc_word_d = flush_pc_i[31:2];
		end
		else if (advance_i) begin
			// One word per consumed slot
			pc_word_d = pc_word_q + 30'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc_word_q <= RESET_WORD;
		end
		else begin
			pc_word_q <= pc_word_d;
		end
	end

	////////////////////////////////////////////////////////////
	// Output
	////////////////////////////////////////////////////////////

	// Byte address, word aligned
	assign pc_o = {pc_word_q, 2'b00};

endmodule

`default_nettype wire

/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

	////////////////////////////////////////////////////////////
	// Response tags
	////////////////////////////////////////////////////////////

	// Kind of a fetch response, carried with err
	typedef enum logic [3:0] {
		ITAG_NONE = 4'h0,
		ITAG_BE   = 4'hb,
		ITAG_PE   = 4'hc,
		ITAG_TE   = 4'hd
	} itag_e;

	// Bus port FSM states
	typedef enum logic [1:0] {
		IBUS_IDLE,
		IBUS_WAIT,
		IBUS_FAULT,
		IBUS_DONE
	} ibus_state_e;

	////////////////////////////////////////////////////////////
	// Instruction words and address map
	////////////////////////////////////////////////////////////

	// l.nop forms, immediate tells the two apart
	localparam logic [31:0] INSN_BUBBLE = {6'b000101, 26'h041_0000};
	localparam logic [31:0] INSN_STALL  = {6'b000101, 26'h061_0000};

	// First fetch address
	localparam logic [31:0] RESET_PC = 32'h0000_0100;

	// Fixed windows in place of an MMU
	localparam logic [31:0] TLB_MISS_BASE = 32'hf000_0000;
	localparam logic [31:0] PROT_BASE     = 32'he000_0000;
	localparam logic [31:0] PROT_LIMIT    = 32'hefff_ffff;

endpackage

`default_nettype wire

/* src/fetch_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,

	// Response from the bus port
	input  logic [31:0] rsp_dat_i,
	input  logic        rsp_ack_i,
	input  logic        rsp_err_i,
	input  logic [31:0] rsp_adr_i,
	input  itag_e       rsp_tag_i,
	input  logic        pending_i,

	// Pipeline control
	input  logic        freeze_i,
	input  logic        flush_i,
	input  logic        kill_i,

	// Slot consumed
	output logic        advance_o,

	// To decode
	output logic [31:0] if_insn_o,
	output logic [31:0] if_pc_o,
	output logic        if_stall_o,
	output logic        saving_o,

	// Exception flags
	output logic        except_itlbmiss_o,
	output logic        except_ipagefault_o,
	output logic        except_ibuserr_o
);

	logic rsp_valid;
	logic bypass;
	logic bypass_q;
	logic save_insn;

	// Saved slot
	logic        saved_q;
	logic [31:0] insn_saved;
	logic [31:0] addr_saved;
	// Bit 0 TLB miss, bit 1 page fault, bit 2 bus error
	logic [2:0]  err_saved;

	// Flags decoded from the live response
	logic [2:0] err_live;

	assign rsp_valid = rsp_ack_i | rsp_err_i;

	assign err_live[0] = rsp_err_i && (rsp_tag_i == ITAG_TE);
	assign err_live[1] = rsp_err_i && (rsp_tag_i == ITAG_PE);
	assign err_live[2] = rsp_err_i && (rsp_tag_i == ITAG_BE);

	////////////////////////////////////////////////////////////
	// Stale response bypass
	////////////////////////////////////////////////////////////

	// Flush cycle itself counts as bypassed
	assign bypass = bypass_q | flush_i;

	// Armed by a flush during a transfer, dropped by its response
	always_ff @(posedge clk) begin
		if (rst_i) begin
			bypass_q <= 1'b0;
		end
		else if (rsp_valid) begin
			bypass_q <= 1'b0;
		end
		else if (flush_i && pending_i) begin
			bypass_q <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Freeze save
	////////////////////////////////////////////////////////////

	// Only a live response is worth keeping
	assign save_insn = rsp_valid && freeze_i && !saved_q && !bypass;
	assign saving_o  = save_insn;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			saved_q <= 1'b0;
		end
		else if (flush_i) begin
			saved_q <= 1'b0;
		end
		else if (save_insn) begin
			saved_q <= 1'b1;
		end
		else if (!freeze_i) begin
			saved_q <= 1'b0;
		end
	end

	// Payload, qualified by saved_q
	always_ff @(posedge clk) begin
		if (save_insn) begin
			insn_saved <= rsp_err_i ? INSN_BUBBLE : rsp_dat_i;
			addr_saved <= rsp_adr_i;
			err_saved  <= err_live;
		end
	end

	////////////////////////////////////////////////////////////
	// Outputs
	////////////////////////////////////////////////////////////

	// Consume when unfrozen and something current is present
	assign advance_o = !freeze_i && (rsp_valid || saved_q) && !bypass;

	always_comb begin
		if (kill_i || bypass) begin
			if_insn_o = INSN_BUBBLE;
		end
		else if (saved_q) begin
			if_insn_o = insn_saved;
		end
		else if (rsp_ack_i) begin
			if_insn_o = rsp_dat_i;
		end
		else if (rsp_err_i) begin
			if_insn_o = INSN_BUBBLE;
		end
		else begin
			// Still waiting on memory
			if_insn_o = INSN_STALL;
		end
	end

	assign if_pc_o    = saved_q ? addr_saved : rsp_adr_i;
	assign if_stall_o = !rsp_valid && !saved_q;

	// Kill and stale slots never raise an exception
	always_comb begin
		if (kill_i || bypass) begin
			{except_ibuserr_o, except_ipagefault_o, except_itlbmiss_o} = 3'b000;
		end
		else if (saved_q) begin
			{except_ibuserr_o, except_ipagefault_o, except_itlbmiss_o} = err_saved;
		end
		else begin
			{except_ibuserr_o, except_ipagefault_o, except_itlbmiss_o} = err_live;
		end
	end

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_top import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_i,

	// Pipeline control
	input  logic        freeze_i,
	input  logic        flush_i,
	input  logic [31:0] flush_pc_i,
	input  logic        kill_i,

	// External memory
	output logic [31:0] ibus_adr_o,
	output logic        ibus_req_o,
	input  logic [31:0] ibus_dat_i,
	input  logic        ibus_ack_i,
	input  logic        ibus_err_i,

	// To decode
	output logic [31:0] if_insn_o,
	output logic [31:0] if_pc_o,
	output logic        if_stall_o,
	output logic        saving_o,
	output logic        except_itlbmiss_o,
	output logic        except_ipagefault_o,
	output logic        except_ibuserr_o
);

	logic [31:0] pc;
	logic        advance;

	// Bus port to stage
	logic [31:0] rsp_dat;
	logic        rsp_ack;
	logic        rsp_err;
	logic [31:0] rsp_adr;
	itag_e       rsp_tag;
	logic        pending;

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	fetch_pc_gen u_pc_gen (
		.clk        (clk),
		.rst_i      (rst_i),
		.advance_i  (advance),
		.flush_i    (flush_i),
		.flush_pc_i (flush_pc_i),
		.pc_o       (pc)
	);

	fetch_ibus_port u_ibus_port (
		.clk        (clk),
		.rst_i      (rst_i),
		.pc_i       (pc),
		.advance_i  (advance),
		.flush_i    (flush_i),
		.ibus_adr_o (ibus_adr_o),
		.ibus_req_o (ibus_req_o),
		.ibus_dat_i (ibus_dat_i),
		.ibus_ack_i (ibus_ack_i),
		.ibus_err_i (ibus_err_i),
		.rsp_dat_o  (rsp_dat),
		.rsp_ack_o  (rsp_ack),
		.rsp_err_o  (rsp_err),
		.rsp_adr_o  (rsp_adr),
		.rsp_tag_o  (rsp_tag),
		.pending_o  (pending)
	);

	fetch_stage u_stage (
		.clk                 (clk),
		.rst_i               (rst_i),
		.rsp_dat_i           (rsp_dat),
		.rsp_ack_i           (rsp_ack),
		.rsp_err_i           (rsp_err),
		.rsp_adr_i           (rsp_adr),
		.rsp_tag_i           (rsp_tag),
		.pending_i           (pending),
		.freeze_i            (freeze_i),
		.flush_i             (flush_i),
		.kill_i              (kill_i),
		.advance_o           (advance),
		.if_insn_o           (if_insn_o),
		.if_pc_o             (if_pc_o),
		.if_stall_o          (if_stall_o),
		.saving_o            (saving_o),
		.except_itlbmiss_o   (except_itlbmiss_o),
		.except_ipagefault_o (except_ipagefault_o),
		.except_ibuserr_o    (except_ibuserr_o)
	);

endmodule

`default_nettype wire

/* testbench/fetch_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_assertions import fetch_pkg::*; (
	input logic        clk,
	input logic        rst_i,

	// Stage inputs and outputs
	input logic        freeze_i,
	input logic        stall_i,
	input logic        kill_i,
	input logic        flush_i,
	input logic        pending_i,
	input logic        ack_i,
	input logic        err_i,
	input logic [31:0] insn_i,
	input logic        itlbmiss_i,
	input logic        ipagefault_i,
	input logic        ibuserr_i
);

	// Failures seen so far, read by the testbench at the end
	int unsigned fail_count = 0;

	logic rsp_valid;
	logic stale_q;
	logic held_q;

	assign rsp_valid = ack_i | err_i;

	// Flush caught a transfer in flight
	// its response is still on the way
	always_ff @(posedge clk) begin
		if (rst_i) begin
			stale_q <= 1'b0;
		end
		else if (rsp_valid) begin
			stale_q <= 1'b0;
		end
		else if (flush_i && pending_i) begin
			stale_q <= 1'b1;
		end
	end

	// Live response taken under freeze
	// held until freeze drops or a flush arrives
	always_ff @(posedge clk) begin
		if (rst_i) begin
			held_q <= 1'b0;
		end
		else if (flush_i || !freeze_i) begin
			held_q <= 1'b0;
		end
		else if (rsp_valid && !stale_q) begin
			held_q <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// Properties
	////////////////////////////////////////////////////////////

	// Held slot is always presented
	a_saved_no_stall: assert property (
		@(posedge clk) disable iff (rst_i) held_q |-> !stall_i
	) else begin
		$error("stall raised while a saved slot is held");
		fail_count++;
	end

	// Killed slot raises nothing
	a_kill_no_except: assert property (
		@(posedge clk) disable iff (rst_i) kill_i |-> !(itlbmiss_i || ipagefault_i || ibuserr_i)
	) else begin
		$error("exception flag raised while kill is high");
		fail_count++;
	end

	// Stale response shows up as a bubble
	a_stale_bubble: assert property (
		@(posedge clk) disable iff (rst_i) (stale_q && rsp_valid) |-> (insn_i == INSN_BUBBLE)
	) else begin
		$error("stale response after flush was not replaced by a bubble");
		fail_count++;
	end

endmodule

bind fetch_stage fetch_assertions u_assertions (
	.clk          (clk),
	.rst_i        (rst_i),
	.freeze_i     (freeze_i),
	.stall_i      (if_stall_o),
	.kill_i       (kill_i),
	.flush_i      (flush_i),
	.pending_i    (pending_i),
	.ack_i        (rsp_ack_i),
	.err_i        (rsp_err_i),
	.insn_i       (if_insn_o),
	.itlbmiss_i   (except_itlbmiss_o),
	.ipagefault_i (except_ipagefault_o),
	.ibuserr_i    (except_ibuserr_o)
);

`default_nettype wire

/* testbench/fetch_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_tb import fetch_pkg::*; ();

	// Run budget, fetches times worst case cycles per fetch
	localparam int N_FETCH     = 60;
	localparam int MAX_WAIT    = 4;
	localparam int CYCLE_LIMIT = N_FETCH * (MAX_WAIT + 2) + 200;

	// Error address and redirect targets
	localparam logic [31:0] ERR_ADR    = 32'h0000_3000;
	localparam logic [31:0] FLUSH_ADR  = 32'h0000_2000;
	localparam logic [31:0] KILL_ADR   = 32'h0000_4000;
	localparam logic [31:0] RESUME_ADR = 32'h0000_5000;

	logic        clk;
	logic        rst_i;
	logic        freeze_i;
	logic        flush_i;
	logic [31:0] flush_pc_i;
	logic        kill_i;
	logic [31:0] ibus_adr_o;
	logic        ibus_req_o;
	logic [31:0] ibus_dat_i;
	logic        ibus_ack_i;
	logic        ibus_err_i;
	logic [31:0] if_insn_o;
	logic [31:0] if_pc_o;
	logic        if_stall_o;
	logic        saving_o;
	logic        except_itlbmiss_o;
	logic        except_ipagefault_o;
	logic        except_ibuserr_o;

	// Memory model state
	integer      seed;
	int          wait_max;
	logic        wait_random;
	logic [31:0] err_adr;
	logic        mem_busy;
	int          wait_left;
	logic        req_seen;
	logic        resp_last;
	logic [31:0] adr_seen;

	// Slots taken by the pipeline, in order
	logic [31:0] slot_pc[$];
	logic [31:0] slot_insn[$];
	logic [2:0]  slot_exc[$];

	logic [31:0] expect_pc;
	logic        check_stall;
	int          errors;
	int          cycle_count;
	int unsigned assert_fails;

	fetch_top dut (
		.clk                 (clk),
		.rst_i               (rst_i),
		.freeze_i            (freeze_i),
		.flush_i             (flush_i),
		.flush_pc_i          (flush_pc_i),
		.kill_i              (kill_i),
		.ibus_adr_o          (ibus_adr_o),
		.ibus_req_o          (ibus_req_o),
		.ibus_dat_i          (ibus_dat_i),
		.ibus_ack_i          (ibus_ack_i),
		.ibus_err_i          (ibus_err_i),
		.if_insn_o           (if_insn_o),
		.if_pc_o             (if_pc_o),
		.if_stall_o          (if_stall_o),
		.saving_o            (saving_o),
		.except_itlbmiss_o   (except_itlbmiss_o),
		.except_ipagefault_o (except_ipagefault_o),
		.except_ibuserr_o    (except_ibuserr_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#4 clk = ~clk;
		end
	end

	// Watchdog
	initial begin
		cycle_count = 0;
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("run stopped, no end of test after %0d cycles", cycle_count);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Memory model
	////////////////////////////////////////////////////////////

	// Wait states for a new transfer
	function automatic int draw_waits();
		if (!wait_random) begin
			return wait_max;
		end
		return {$random(seed)} % (wait_max + 1);
	endfunction

	// Bus seen at the falling edge, answer driven after the next rising edge
	// data is the inverse of the address
	initial begin
		ibus_dat_i = '0;
		ibus_ack_i = 1'b0;
		ibus_err_i = 1'b0;
		mem_busy   = 1'b0;
		wait_left  = 0;
		forever begin
			@(negedge clk);
			req_seen  = ibus_req_o;
			adr_seen  = ibus_adr_o;
			resp_last = ibus_ack_i | ibus_err_i;
			@(posedge clk);
			#1;
			ibus_ack_i = 1'b0;
			ibus_err_i = 1'b0;
			// Request still up after an answer belongs to the old transfer
			if (!req_seen || resp_last) begin
				mem_busy = 1'b0;
			end
			else begin
				if (!mem_busy) begin
					mem_busy  = 1'b1;
					wait_left = draw_waits();
				end
				if (wait_left == 0) begin
					ibus_dat_i = ~adr_seen;
					ibus_ack_i = adr_seen != err_adr;
					ibus_err_i = adr_seen == err_adr;
					mem_busy   = 1'b0;
				end
				else begin
					wait_left = wait_left - 1;
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Slot monitor
	////////////////////////////////////////////////////////////

	initial begin
		forever begin
			@(negedge clk);
			// Presented and not frozen, so consumed
			if (!rst_i && !if_stall_o && !freeze_i) begin
				slot_pc.push_back(if_pc_o);
				slot_insn.push_back(if_insn_o);
				slot_exc.push_back({except_ibuserr_o, except_ipagefault_o, except_itlbmiss_o});
			end
			if (check_stall && if_stall_o && (if_insn_o !== INSN_STALL)) begin
				report_mismatch("if_insn_o", if_insn_o, INSN_STALL);
			end
			// Window faults never reach the bus
			if (ibus_req_o && (ibus_adr_o >= PROT_BASE)) begin
				report_failure("bus request raised for a fault window address");
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		errors++;
		$display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("at %0t: %s", $time, msg);
	endtask

	// Drive point, 1 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic clear_slots();
		slot_pc.delete();
		slot_insn.delete();
		slot_exc.delete();
	endtask

	task automatic wait_slots(input int n);
		while (slot_pc.size() < n) begin
			next_cycle();
		end
	endtask

	task automatic wait_for_pc(input logic [31:0] pc, output int idx);
		idx = -1;
		while (idx < 0) begin
			next_cycle();
			foreach (slot_pc[i]) begin
				if (idx < 0 && slot_pc[i] == pc) begin
					idx = i;
				end
			end
		end
	endtask

	// One cycle flush pulse, slot record starts fresh
	task automatic redirect(input logic [31:0] target);
		clear_slots();
		flush_i    = 1'b1;
		flush_pc_i = target;
		next_cycle();
		flush_i    = 1'b0;
	endtask

	// Consecutive words from expect_pc, each the inverse of its address
	task automatic check_sequence(input int n);
		logic [31:0] exp_pc;
		for (int i = 0; i < n; i++) begin
			exp_pc = expect_pc + 32'(4 * i);
			if (slot_pc[i] !== exp_pc) begin
				report_mismatch("if_pc_o", slot_pc[i], exp_pc);
			end
			if (slot_insn[i] !== ~exp_pc) begin
				report_mismatch("if_insn_o", slot_insn[i], ~exp_pc);
			end
			if (slot_exc[i] !== 3'b000) begin
				report_mismatch("exception flags", 32'(slot_exc[i]), 32'h0);
			end
		end
		expect_pc = expect_pc + 32'(4 * n);
	endtask

	task automatic redirect_and_check(input logic [31:0] target, input logic [2:0] exp_exc);
		int idx;
		redirect(target);
		wait_for_pc(target, idx);
		if (slot_insn[idx] !== INSN_BUBBLE) begin
			report_mismatch("if_insn_o", slot_insn[idx], INSN_BUBBLE);
		end
		if (slot_exc[idx] !== exp_exc) begin
			report_mismatch("exception flags", 32'(slot_exc[idx]), 32'(exp_exc));
		end
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////

	task automatic sequential_fetch();
		wait_random = 1'b0;
		wait_max    = 0;
		expect_pc   = RESET_PC;
		clear_slots();
		wait_slots(8);
		check_sequence(8);
	endtask

	task automatic random_wait_fetch();
		wait_random = 1'b1;
		wait_max    = MAX_WAIT;
		check_stall = 1'b1;
		clear_slots();
		wait_slots(12);
		check_sequence(12);
		check_stall = 1'b0;
	endtask

	task automatic freeze_hold();
		logic        saw_save;
		logic [31:0] held_pc;
		logic [31:0] held_insn;
		wait_random = 1'b0;
		wait_max    = 1;
		saw_save    = 1'b0;
		clear_slots();
		wait_slots(2);
		freeze_i = 1'b1;
		while (!saw_save) begin
			@(negedge clk);
			if (saving_o) begin
				saw_save  = 1'b1;
				held_pc   = if_pc_o;
				held_insn = if_insn_o;
			end
		end
		// Frozen outputs hold the saved slot
		repeat (3) begin
			@(negedge clk);
			if (saving_o) begin
				report_failure("saving_o high for more than one cycle");
			end
			if (if_pc_o !== held_pc) begin
				report_mismatch("if_pc_o", if_pc_o, held_pc);
			end
			if (if_insn_o !== held_insn) begin
				report_mismatch("if_insn_o", if_insn_o, held_insn);
			end
			if (if_stall_o) begin
				report_failure("if_stall_o high while a saved slot is held");
			end
			if (ibus_req_o) begin
				report_failure("new bus request issued under freeze");
			end
		end
		next_cycle();
		freeze_i = 1'b0;
		wait_slots(6);
		check_sequence(6);
	endtask

	task automatic flush_redirect();
		wait_random = 1'b0;
		wait_max    = 3;
		// Sync to a response, then hit the middle of the next transfer
		@(negedge clk);
		while (if_stall_o) begin
			@(negedge clk);
		end
		@(negedge clk);
		@(negedge clk);
		next_cycle();
		redirect(FLUSH_ADR);
		wait_slots(2);
		if (slot_insn[0] !== INSN_BUBBLE) begin
			report_mismatch("if_insn_o", slot_insn[0], INSN_BUBBLE);
		end
		if (slot_pc[1] !== FLUSH_ADR) begin
			report_mismatch("if_pc_o", slot_pc[1], FLUSH_ADR);
		end
		if (slot_insn[1] !== ~FLUSH_ADR) begin
			report_mismatch("if_insn_o", slot_insn[1], ~FLUSH_ADR);
		end
	endtask

	task automatic fault_classes();
		wait_max = 0;
		err_adr  = ERR_ADR;
		redirect_and_check(TLB_MISS_BASE + 32'h40, 3'b001);
		redirect_and_check(PROT_BASE + 32'h1000, 3'b010);
		redirect_and_check(ERR_ADR, 3'b100);
	endtask

	task automatic kill_slots();
		int idx;
		kill_i = 1'b1;
		// Bubble and no flag, for a fault and for a plain word
		redirect_and_check(TLB_MISS_BASE + 32'h200, 3'b000);
		redirect_and_check(KILL_ADR, 3'b000);
		kill_i = 1'b0;
		redirect(RESUME_ADR);
		wait_for_pc(RESUME_ADR, idx);
		if (slot_insn[idx] !== ~RESUME_ADR) begin
			report_mismatch("if_insn_o", slot_insn[idx], ~RESUME_ADR);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		seed        = 32'hd722_4c50;
		errors      = 0;
		wait_max    = 0;
		wait_random = 1'b0;
		check_stall = 1'b0;
		err_adr     = 32'h0000_0003;
		expect_pc   = RESET_PC;
		rst_i       = 1'b1;
		freeze_i    = 1'b0;
		flush_i     = 1'b0;
		flush_pc_i  = '0;
		kill_i      = 1'b0;
		repeat (4) begin
			next_cycle();
		end
		rst_i = 1'b0;

		sequential_fetch();
		random_wait_fetch();
		freeze_hold();
		flush_redirect();
		fault_classes();
		kill_slots();

		repeat (4) begin
			next_cycle();
		end
		assert_fails = dut.u_stage.u_assertions.fail_count;
		$display("errors %0d, assertion failures %0d", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("TEST OK");
		end
		else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
